/* vlog.f */
source/core_fetch_pkg.sv
source/core_fetch_resp_filter.sv
source/core_pipe_fetch_buffer.sv
source/core_pipe_fetch.sv
source/core_fetch_top.sv
sim/fetch_clkgen.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: sim clean

# Build, run, then fail unless the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/fetch_tb.sv */
// ----------------------------------------------------------------------
// Testbench top for the fetch front end
// Instruction memory model, decode and redirect stimulus, test sequence
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fetch_tb
    import core_fetch_pkg::*;
;

    localparam logic [xlen-1:0] reset_pc = 32'h1000_0000;
    localparam int clk_period_ns = 8;
    localparam int n_seq   = 40;  // Instructions per test
    localparam int n_bp    = 60;
    localparam int n_off   = 30;
    localparam int n_fly   = 24;
    localparam int n_err   = 40;
    localparam int timeout_cycles = 40 * (n_seq + n_bp + n_off + n_fly + n_err);

    logic            g_clk;
    logic            g_resetn;
    cf_req_t         cf_drive = '0;
    logic            cf_ack;
    imem_req_t       imem_req;
    imem_rsp_t       imem_rsp = '0;
    fetch_out_t      fetch_out;
    logic            eat_2 = 1'b0;
    logic            eat_4 = 1'b0;
    logic [xlen-1:0] err_lo;          // Error window, set once
    logic [xlen-1:0] gnt_addr;        // Address of granted word
    logic [xlen-1:0] straddle_pc;     // 32 bit instr across words
    int              gnt_slack;       // Grant odds 1 in slack+1
    int              stall_en;        // Decode withholds eats
    int              stall_left;
    int              checked_count;
    int              error_count;
    int              test_count;
    int              test_checked;
    int              test_errors;

    fetch_clkgen #(.period_ns(clk_period_ns), .reset_cycles(3)) i_fetch_clkgen (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    core_fetch_top #(.PC_RESET_ADDRESS(reset_pc)) i_core_fetch_top (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf        (cf_drive),
        .cf_ack    (cf_ack),
        .imem_o    (imem_req),
        .imem_i    (imem_rsp),
        .fetch_out (fetch_out),
        .eat_2     (eat_2),
        .eat_4     (eat_4)
    );

    fetch_checker #(.PC_RESET_ADDRESS(reset_pc)) i_fetch_checker (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .cf            (cf_drive),
        .cf_ack        (cf_ack),
        .imem_o        (imem_req),
        .imem_i        (imem_rsp),
        .fetch_out     (fetch_out),
        .eat_2         (eat_2),
        .eat_4         (eat_4),
        .err_lo        (err_lo),
        .checked_count (checked_count),
        .error_count   (error_count)
    );

    // ------------------------------------------------------------------
    // Instruction memory model
    // ------------------------------------------------------------------

    function automatic logic [15:0] mem_half(input logic [xlen-1:0] a);
        logic [15:0] h;
        h = a[31:16] ^ (a[15:0] * 16'h9e37) ^ {a[7:0], a[15:8]};
        if (^(a & 32'h0000_0176)) h[1:0] = 2'b11;       // Second hash picks width
        else if (h[1:0] == 2'b11) h[1:0] = 2'b01;
        return h;
    endfunction

    function automatic logic [mem_data_w-1:0] mem_word(input logic [xlen-1:0] w);
        return {mem_half(w + 32'd6), mem_half(w + 32'd4), mem_half(w + 32'd2), mem_half(w)};
    endfunction

    // First offset 6 halfword at or after start that opens a 32 bit instr
    function automatic logic [xlen-1:0] find_straddle(input logic [xlen-1:0] start);
        logic [xlen-1:0] a;
        logic [15:0]     h;
        a = start;
        h = mem_half(a);
        while (h[1:0] != 2'b11) begin
            a = a + 32'd8;
            h = mem_half(a);
        end
        return a;
    endfunction

    always @(posedge g_clk) begin
        #1;
        if (imem_rsp.gnt) begin  // Granted last cycle, data now
            imem_rsp.rdata = mem_word(gnt_addr);
            imem_rsp.err   = (gnt_addr >= err_lo) && (gnt_addr < err_lo + 32'd32);
        end else begin
            imem_rsp.rdata = '0;
            imem_rsp.err   = 1'b0;
        end
        if (imem_req.req === 1'b1 && $urandom_range(gnt_slack, 0) == 0) begin
            imem_rsp.gnt = 1'b1;
            gnt_addr     = imem_req.addr;
        end else begin
            imem_rsp.gnt = 1'b0;  // Random back-pressure
        end
    end

    // ------------------------------------------------------------------
    // Decode and redirect stimulus
    // ------------------------------------------------------------------

    always @(posedge g_clk) begin
        #1;
        eat_2 = 1'b0;
        eat_4 = 1'b0;
        if (stall_left > 0) stall_left--;
        else if (stall_en != 0 && $urandom_range(7, 0) == 0) stall_left = $urandom_range(30, 1);
        else if (fetch_out.i16bit === 1'b1) eat_2 = 1'b1;
        else if (fetch_out.i32bit === 1'b1) eat_4 = 1'b1;
    end

    // Called just after an edge, returns just after the accepting edge
    task automatic redirect_to(input logic [xlen-1:0] target);
        logic accepted;
        cf_drive.valid  = 1'b1;
        cf_drive.target = target;
        accepted        = 1'b0;
        while (!accepted) begin
            @(negedge g_clk);
            accepted = cf_ack;  // Stable until the edge
            @(posedge g_clk);
            #1;
        end
        cf_drive.valid = 1'b0;
    endtask

    task automatic wait_checks(input int n);
        int goal;
        goal = checked_count + n;
        while (checked_count < goal) begin
            @(posedge g_clk);
            #1;
        end
    endtask

    task automatic begin_test();
        test_checked = checked_count;
        test_errors  = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d instructions checked, %0d errors", test_count, name,
                 checked_count - test_checked, error_count - test_errors);
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin
        void'($urandom(8));
        gnt_slack   = 0;
        stall_en    = 0;
        stall_left  = 0;
        test_count  = 0;
        err_lo      = find_straddle(32'h1000_4006) + 32'd2;  // Good word then bad word
        straddle_pc = find_straddle(32'h1000_1806);
        while (g_resetn !== 1'b1) @(posedge g_clk);
        @(posedge g_clk);
        #1;

        begin_test();
        wait_checks(n_seq);
        end_test("sequential fetch");

        begin_test();
        gnt_slack = 3;
        stall_en  = 1;
        wait_checks(n_bp);
        stall_en  = 0;
        end_test("decode back-pressure");

        begin_test();
        for (int k = 0; k < 4; k++) begin  // Offsets 0, 2, 4, 6
            redirect_to(32'h1000_1000 + 32'(k) * 32'h100 + 32'(2 * k));
            wait_checks(6);
        end
        redirect_to(straddle_pc);
        wait_checks(6);
        end_test("redirect offsets");

        begin_test();
        repeat (12) begin
            repeat ($urandom_range(3, 0)) begin
                @(posedge g_clk);
                #1;
            end
            redirect_to(32'h1000_2000 + ($urandom_range(2047, 0) << 1));
            wait_checks(2);
        end
        end_test("redirect in flight");

        begin_test();
        gnt_slack = 2;
        redirect_to(err_lo - 32'd2);  // Straddles into the window, then runs through it
        wait_checks(n_err);
        end_test("fetch error tags");

        $display("%0d tests run, %0d instructions checked, %0d errors",
                 test_count, checked_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(timeout_cycles * clk_period_ns);
        $display("timeout: run did not finish within %0d cycles", timeout_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/fetch_checker.sv */
// ----------------------------------------------------------------------
// Reference model of the expected instruction stream
// Compares every accepted decode eat and checks buffer accounting
// Checks the redirect and memory request handshakes
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fetch_checker
    import core_fetch_pkg::*;
#(
    parameter logic [xlen-1:0] PC_RESET_ADDRESS = 32'h1000_0000  // First expected pc
) (
    input  logic            g_clk,          // Clock
    input  logic            g_resetn,       // Sync reset, active low
    input  cf_req_t         cf,             // Redirect as driven
    input  logic            cf_ack,         // Redirect accepted
    input  imem_req_t       imem_o,         // Memory request
    input  imem_rsp_t       imem_i,         // Memory response
    input  fetch_out_t      fetch_out,      // Decode side
    input  logic            eat_2,          // Decode eats 2 bytes
    input  logic            eat_4,          // Decode eats 4 bytes
    input  logic [xlen-1:0] err_lo,         // Start of error window
    output int              checked_count,  // Instructions compared
    output int              error_count     // Failed checks
);

    localparam int err_bytes = 32;  // Error window length

    logic [xlen-1:0]       exp_pc;         // Next instruction expected
    int                    fetched_bytes;  // 8 per grant
    int                    eaten_bytes;    // 2 or 4 per eat
    logic                  redirected;     // Accounting only valid before
    logic                  req_waiting;    // Request seen without gnt
    logic [mem_addr_w-1:0] req_addr;       // Its address

    // ------------------------------------------------------------------
    // Reference
    // ------------------------------------------------------------------

    // Halfword at byte address a, low bits pick 16 or 32 bit encoding
    function automatic logic [15:0] ref_half(input logic [xlen-1:0] a);
        logic [15:0] h;
        h = a[31:16] ^ (a[15:0] * 16'h9e37) ^ {a[7:0], a[15:8]};
        if (^(a & 32'h0000_0176)) begin
            h[1:0] = 2'b11;  // Full width
        end else if (h[1:0] == 2'b11) begin
            h[1:0] = 2'b01;  // Compressed
        end
        return h;
    endfunction

    function automatic logic ref_err(input logic [xlen-1:0] a);
        logic [xlen-1:0] w;
        w = {a[xlen-1:3], 3'b000};  // Error is per fetch word
        return (w >= err_lo) && (w < err_lo + err_bytes);
    endfunction

    // ------------------------------------------------------------------
    // Compare
    // ------------------------------------------------------------------

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH %s at pc %h: got %h expected %h", sig, exp_pc, got, exp);
        error_count++;
    endtask

    task automatic compare_instr();
        logic [15:0] lo;
        logic [15:0] hi;
        logic        exp32;
        logic [1:0]  exp_flags;
        logic [1:0]  got_flags;
        lo        = ref_half(exp_pc);
        hi        = ref_half(exp_pc + 32'd2);  // May sit in the next word
        exp32     = lo[1:0] == 2'b11;
        exp_flags = {exp32, !exp32};
        got_flags = {fetch_out.i32bit, fetch_out.i16bit};
        if (got_flags != exp_flags) begin
            report_mismatch("fetch_out.{i32bit,i16bit}", {30'b0, got_flags}, {30'b0, exp_flags});
        end else if (exp32) begin
            if (fetch_out.instr != {hi, lo})
                report_mismatch("fetch_out.instr", fetch_out.instr, {hi, lo});
            if (fetch_out.ferr != {ref_err(exp_pc + 32'd2), ref_err(exp_pc)})
                report_mismatch("fetch_out.ferr", {30'b0, fetch_out.ferr},
                                {30'b0, ref_err(exp_pc + 32'd2), ref_err(exp_pc)});
        end else begin
            if (fetch_out.instr[15:0] != lo)  // Upper half is next instr
                report_mismatch("fetch_out.instr[15:0]", {16'h0, fetch_out.instr[15:0]},
                                {16'h0, lo});
            if (fetch_out.ferr[0] != ref_err(exp_pc))
                report_mismatch("fetch_out.ferr[0]", {31'b0, fetch_out.ferr[0]},
                                {31'b0, ref_err(exp_pc)});
        end
        checked_count++;
    endtask

    // Inputs change just after posedge, so negedge sees the edge values
    always @(negedge g_clk) begin
        if (!g_resetn) begin
            exp_pc        = PC_RESET_ADDRESS;
            checked_count = 0;
            error_count   = 0;
            fetched_bytes = 0;
            eaten_bytes   = 0;
            redirected    = 1'b0;
            req_waiting   = 1'b0;
            req_addr      = '0;
        end else begin
            // Redirect only when no request waits for its grant
            if (cf_ack !== (!imem_o.req || imem_i.gnt))
                report_mismatch("cf_ack", {31'b0, cf_ack}, {31'b0, !imem_o.req || imem_i.gnt});
            if (req_waiting && (!imem_o.req || imem_o.addr != req_addr)) begin
                $display("memory request at %h dropped or moved before its grant", req_addr);
                error_count++;
            end
            req_waiting = imem_o.req && !imem_i.gnt;
            req_addr    = imem_o.addr;
            if (imem_o.req && imem_i.gnt)
                fetched_bytes += 8;
            if ((eat_2 && fetch_out.i16bit) || (eat_4 && fetch_out.i32bit)) begin
                compare_instr();
                exp_pc      = exp_pc + (eat_4 ? 32'd4 : 32'd2);  // Follow what decode took
                eaten_bytes += eat_4 ? 4 : 2;
            end
            // Buffer plus one word in flight must fit
            if (!redirected && fetched_bytes - eaten_bytes > buf_bytes) begin
                $display("buffer accounting: %0d bytes fetched ahead of decode, more than %0d",
                         fetched_bytes - eaten_bytes, buf_bytes);
                error_count++;
            end
            if (cf.valid && cf_ack) begin
                exp_pc     = cf.target;  // After any eat this cycle
                redirected = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* sim/fetch_clkgen.sv */
// ----------------------------------------------------------------------
// Clock and reset generator for the fetch testbench
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module fetch_clkgen #(
    parameter int period_ns    = 8,  // Clock period
    parameter int reset_cycles = 3   // Reset held this many edges
) (
    output logic g_clk,     // Free running clock
    output logic g_resetn   // Sync reset, active low
);

    initial begin
        g_clk = 1'b0;
        forever #(period_ns / 2) g_clk = ~g_clk;
    end

    initial begin
        g_resetn = 1'b0;
        repeat (reset_cycles) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;  // Released just after an edge
    end

endmodule

`default_nettype wire

/* source/core_fetch_top.sv */
// --------------------------------------------------------------------
// Fetch front end top level
// Fetch stage with its response filter and fetch buffer
// --------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_fetch_top
    import core_fetch_pkg::*;
#(
    parameter logic [xlen-1:0] PC_RESET_ADDRESS = 32'h1000_0000  // Post reset fetch addr
) (
    input  logic       g_clk,      // Clock
    input  logic       g_resetn,   // Sync reset, active low
    input  cf_req_t    cf,         // Redirect from later stages
    output logic       cf_ack,     // Redirect accepted
    output imem_req_t  imem_o,     // Instruction memory request
    input  imem_rsp_t  imem_i,     // Instruction memory response
    output fetch_out_t fetch_out,  // Instruction toward decode
    input  logic       eat_2,      // Decode took 2 bytes
    input  logic       eat_4       // Decode took 4 bytes
);

    // ----------------------------------------------------------------
    // Fetch stage
    // ----------------------------------------------------------------

    // Filter and buffer sit below the fetch stage
    core_pipe_fetch #(
        .PC_RESET_ADDRESS (PC_RESET_ADDRESS)
    ) i_core_pipe_fetch (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf        (cf),
        .cf_ack    (cf_ack),
        .imem_o    (imem_o),
        .imem_i    (imem_i),
        .fetch_out (fetch_out),
        .eat_2     (eat_2),
        .eat_4     (eat_4)
    );

endmodule

`default_nettype wire

/* source/core_pipe_fetch.sv */
// --------------------------------------------------------------------
// Instruction fetch stage
// Fetch address, memory requests, redirect handling and fill sizes
// Presents 16/32 bit instructions from the fetch buffer to decode
// --------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_pipe_fetch
    import core_fetch_pkg::*;
#(
    parameter logic [xlen-1:0] PC_RESET_ADDRESS = 32'h1000_0000  // Post reset fetch addr
) (
    input  logic       g_clk,      // Clock
    input  logic       g_resetn,   // Sync reset, active low
    input  cf_req_t    cf,         // Control flow change
    output logic       cf_ack,     // Change accepted
    output imem_req_t  imem_o,     // Toward instruction memory
    input  imem_rsp_t  imem_i,     // From instruction memory
    output fetch_out_t fetch_out,  // Toward decode
    input  logic       eat_2,      // Decode consumes 2 bytes
    input  logic       eat_4       // Decode consumes 4 bytes
);

    // ----------------------------------------------------------------
    // Events
    // ----------------------------------------------------------------

    logic                   imem_req_q;    // Request held until gnt
    logic                   imem_recv_q;   // Response data this cycle
    logic [mem_addr_w-1:0]  imem_addr_q;
    logic                   e_cf;
    logic                   e_req;
    logic                   ignore_rsp;    // Old path data arriving

    assign e_cf  = cf.valid && cf_ack;
    assign e_req = imem_req_q && imem_i.gnt;

    assign cf_ack = !imem_req_q || imem_i.gnt;  // Never mid request

    // ----------------------------------------------------------------
    // Address and request tracking
    // ----------------------------------------------------------------

    logic                   buf_ready;     // Room for another word
    logic                   n_imem_req;
    logic [mem_addr_w-1:0]  n_imem_addr;

    assign n_imem_req  = buf_ready || (imem_req_q && !imem_i.gnt);
    assign n_imem_addr = imem_addr_q + mem_addr_w'(8);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req_q  <= 1'b0;
            imem_recv_q <= 1'b0;
            imem_addr_q <= PC_RESET_ADDRESS;
        end else begin
            imem_req_q  <= n_imem_req;
            imem_recv_q <= e_req;  // Data one cycle after gnt
            if (e_cf) begin
                imem_addr_q <= {cf.target[mem_addr_w-1:3], 3'b000};
            end else if (e_req) begin
                imem_addr_q <= n_imem_addr;
            end
        end
    end

    assign imem_o.req  = imem_req_q;
    assign imem_o.addr = imem_addr_q;

    // ----------------------------------------------------------------
    // Fill size control
    // ----------------------------------------------------------------

    logic                   first_req_post_cf;  // New path word not yet granted
    logic                   n_first_req_post_cf;
    logic                   buf_fill_2;
    logic                   buf_fill_4;
    logic                   buf_fill_6;
    logic                   buf_fill_8;

    assign n_first_req_post_cf = e_cf || (first_req_post_cf && !e_req);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            first_req_post_cf <= 1'b0;
        end else begin
            first_req_post_cf <= n_first_req_post_cf;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            buf_fill_2 <= 1'b0;
            buf_fill_4 <= 1'b0;
            buf_fill_6 <= 1'b0;
            buf_fill_8 <= 1'b0;
        end else if (e_cf) begin
            // Keep only bytes from the target offset upward
            buf_fill_2 <= cf.target[2:0] == 3'd6;
            buf_fill_4 <= cf.target[2:0] == 3'd4;
            buf_fill_6 <= cf.target[2:0] == 3'd2;
            buf_fill_8 <= cf.target[2:0] == 3'd0;
        end else if (ignore_rsp || first_req_post_cf) begin
            // Hold partial size for the first new path word
        end else begin
            buf_fill_2 <= 1'b0;
            buf_fill_4 <= 1'b0;
            buf_fill_6 <= 1'b0;
            buf_fill_8 <= e_req;  // Whole word in sequence
        end
    end

    // ----------------------------------------------------------------
    // Buffer and decode side
    // ----------------------------------------------------------------

    logic                   buf_fill_en;
    logic [buf_depth_w-1:0] buf_depth;
    logic [buf_depth_w-1:0] buf_n_depth;
    logic [31:0]            buf_data_out;
    logic [1:0]             buf_error_out;
    logic                   buf_drain_2;
    logic                   buf_drain_4;
    logic                   i16bit;
    logic                   i32bit;

    assign buf_fill_en = imem_recv_q && !ignore_rsp;
    assign buf_ready   = (buf_n_depth <= 5'd8) && !e_req;

    assign i16bit = (buf_depth >= 5'd2) && (buf_data_out[1:0] != 2'b11);
    assign i32bit = (buf_depth >= 5'd4) && (buf_data_out[1:0] == 2'b11);

    assign buf_drain_2 = i16bit && eat_2;  // Stray eats ignored
    assign buf_drain_4 = i32bit && eat_4;

    assign fetch_out.i16bit = i16bit;
    assign fetch_out.i32bit = i32bit;
    assign fetch_out.instr  = buf_data_out;
    assign fetch_out.ferr   = buf_error_out;

    core_fetch_resp_filter i_core_fetch_resp_filter (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .e_req      (e_req),
        .e_recv     (imem_recv_q),
        .e_cf       (e_cf),
        .ignore_rsp (ignore_rsp)
    );

    core_pipe_fetch_buffer i_core_pipe_fetch_buffer (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .flush     (e_cf),           // Redirect empties buffer
        .fill_en   (buf_fill_en),
        .fill_2    (buf_fill_2),
        .fill_4    (buf_fill_4),
        .fill_6    (buf_fill_6),
        .fill_8    (buf_fill_8),
        .data_in   (imem_i.rdata),
        .error_in  (imem_i.err),
        .drain_2   (buf_drain_2),
        .drain_4   (buf_drain_4),
        .depth     (buf_depth),
        .n_depth   (buf_n_depth),
        .data_out  (buf_data_out),
        .error_out (buf_error_out)
    );

    // Later stages hold a redirect until it is taken
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf.valid && !cf_ack |=> cf.valid && $stable(cf.target))
        else $error("fetch: redirect dropped or changed before acknowledge");

endmodule

`default_nettype wire

/* source/core_pipe_fetch_buffer.sv */
// --------------------------------------------------------------------
// Byte shifting fetch buffer, 16 bytes deep
// Fills 2/4/6/8 top bytes of a fetch word, drains 2/4 from the bottom
// One bus error tag per halfword
// --------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_pipe_fetch_buffer
    import core_fetch_pkg::*;
(
    input  logic                   g_clk,      // Clock
    input  logic                   g_resetn,   // Sync reset, active low
    input  logic                   flush,      // Empty the buffer
    input  logic                   fill_en,    // Append selected bytes
    input  logic                   fill_2,     // Top 2 bytes of data_in
    input  logic                   fill_4,     // Top 4 bytes
    input  logic                   fill_6,     // Top 6 bytes
    input  logic                   fill_8,     // Whole word
    input  logic [mem_data_w-1:0]  data_in,    // Fetch word
    input  logic                   error_in,   // Word had a bus error
    input  logic                   drain_2,    // Consume 2 bytes
    input  logic                   drain_4,    // Consume 4 bytes
    output logic [buf_depth_w-1:0] depth,      // Bytes held now
    output logic [buf_depth_w-1:0] n_depth,    // Bytes held after edge
    output logic [31:0]            data_out,   // Oldest 4 bytes
    output logic [1:0]             error_out   // Tags of oldest 2 halfwords
);

    localparam int data_w = buf_bytes * 8;  // Storage bits
    localparam int hw_n   = buf_bytes / 2;  // Halfword tags
    localparam logic [buf_depth_w-1:0] word_bytes = buf_depth_w'(mem_data_w / 8);

    logic [data_w-1:0]      data_q;       // Byte 0 is oldest
    logic [hw_n-1:0]        err_q;        // Bit 0 tags halfword 0
    logic [buf_depth_w-1:0] depth_q;

    logic [buf_depth_w-1:0] drain_bytes;  // 0, 2 or 4
    logic [buf_depth_w-1:0] fill_bytes;   // 0 to 8
    logic [buf_depth_w-1:0] base;         // Depth after drain
    logic [data_w-1:0]      shifted;
    logic [data_w-1:0]      keep_mask;    // Bytes below base survive
    logic [mem_data_w-1:0]  fill_top;     // Selected bytes moved down
    logic [data_w-1:0]      fill_word;    // Placed at base
    logic [data_w-1:0]      n_data;
    logic [hw_n-1:0]        err_shifted;
    logic [hw_n-1:0]        err_keep;
    logic [hw_n-1:0]        err_fill;
    logic [hw_n-1:0]        n_err;

    // ----------------------------------------------------------------
    // Drain and fill sizes
    // ----------------------------------------------------------------

    assign drain_bytes = drain_4 ? 5'd4 :
                         drain_2 ? 5'd2 : 5'd0;

    always_comb begin
        fill_bytes = '0;
        if (fill_en) begin
            if (fill_8) fill_bytes = 5'd8;
            if (fill_6) fill_bytes = 5'd6;
            if (fill_4) fill_bytes = 5'd4;
            if (fill_2) fill_bytes = 5'd2;
        end
    end

    assign base = depth_q - drain_bytes;

    // ----------------------------------------------------------------
    // Next contents
    // ----------------------------------------------------------------

    assign shifted   = data_q >> {drain_bytes, 3'b000};
    assign keep_mask = ~({data_w{1'b1}} << {base, 3'b000});

    // Top fill_bytes of the word, zero above them
    assign fill_top  = data_in >> {word_bytes - fill_bytes, 3'b000};
    assign fill_word = {{(data_w - mem_data_w){1'b0}}, fill_top} << {base, 3'b000};

    assign n_data = (shifted & keep_mask) | fill_word;

    // Same merge on halfword tags
    assign err_shifted = err_q >> drain_bytes[buf_depth_w-1:1];
    assign err_keep    = ~({hw_n{1'b1}} << base[buf_depth_w-1:1]);
    assign err_fill    = (error_in ? ~({hw_n{1'b1}} << fill_bytes[buf_depth_w-1:1]) : '0)
                         << base[buf_depth_w-1:1];

    assign n_err = (err_shifted & err_keep) | err_fill;

    assign n_depth = flush ? '0 : base + fill_bytes;  // Flush beats fill

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            depth_q <= '0;
        end else begin
            depth_q <= n_depth;
        end
    end

    always_ff @(posedge g_clk) begin
        data_q <= n_data;  // Bytes above depth are don't care
        err_q  <= n_err;
    end

    // ----------------------------------------------------------------
    // Outputs
    // ----------------------------------------------------------------

    assign depth     = depth_q;
    assign data_out  = data_q[31:0];
    assign error_out = err_q[1:0];

    // Fill size registers in the fetch stage are mutually exclusive
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        $onehot0({fill_2, fill_4, fill_6, fill_8}))
        else $error("fetch buffer: fill sizes not one-hot");

    // Request rule upstream keeps room for one full word
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        depth_q <= buf_depth_w'(buf_bytes))
        else $error("fetch buffer: overflow, depth %0d", depth_q);

endmodule

`default_nettype wire

/* source/core_fetch_resp_filter.sv */
// --------------------------------------------------------------------
// Response filter for the fetch stage
// Tracks granted requests in flight and drops their data on redirect
// --------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_fetch_resp_filter
    import core_fetch_pkg::*;
(
    input  logic g_clk,       // Clock
    input  logic g_resetn,    // Sync reset, active low
    input  logic e_req,       // Request granted this cycle
    input  logic e_recv,      // Response data this cycle
    input  logic e_cf,        // Redirect accepted this cycle
    output logic ignore_rsp   // Drop this cycle's response
);

    // ----------------------------------------------------------------
    // Counters
    // ----------------------------------------------------------------

    logic [1:0] reqs_outstanding;    // Granted, data not yet back
    logic [1:0] n_reqs_outstanding;
    logic [1:0] rsps_ignore;         // Old path responses still due

    assign n_reqs_outstanding = reqs_outstanding + {1'b0, e_req} - {1'b0, e_recv};

    assign ignore_rsp = |rsps_ignore;  // From registers only

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            reqs_outstanding <= 2'b00;
            rsps_ignore      <= 2'b00;
        end else begin
            reqs_outstanding <= n_reqs_outstanding;
            if (e_cf) begin
                // Everything still due after this edge is old path
                rsps_ignore <= n_reqs_outstanding;
            end else if (ignore_rsp && e_recv) begin
                rsps_ignore <= rsps_ignore - 2'd1;  // One dropped
            end
        end
    end

    // ----------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------

    // Grant side must respect the one-ahead limit of the fetch stage
    assert property (@(posedge g_clk) disable iff (!g_resetn)
        reqs_outstanding <= 2'd2)
        else $error("fetch filter: more than 2 requests outstanding");

endmodule

`default_nettype wire

/* source/core_fetch_pkg.sv */
// --------------------------------------------------------------------
// Shared widths and bus structs of the instruction fetch front end
// Memory request and response, decode side and control flow change
// --------------------------------------------------------------------

`default_nettype none

package core_fetch_pkg;

    // ----------------------------------------------------------------
    // Widths
    // ----------------------------------------------------------------

    localparam int xlen        = 32;  // Architectural address width
    localparam int mem_addr_w  = 32;  // Instruction memory address
    localparam int mem_data_w  = 64;  // One 8 byte fetch word
    localparam int buf_bytes   = 16;  // Fetch buffer capacity
    localparam int buf_depth_w = 5;   // Holds 0 to 16

    // ----------------------------------------------------------------
    // Bus structs
    // ----------------------------------------------------------------

    typedef struct packed {
        logic                  req;    // Read request
        logic [mem_addr_w-1:0] addr;   // 8 byte aligned
    } imem_req_t;

    typedef struct packed {
        logic                  gnt;    // Request accepted
        logic                  err;    // Bus error, cycle after gnt
        logic [mem_data_w-1:0] rdata;  // Read data, cycle after gnt
    } imem_rsp_t;

    typedef struct packed {
        logic        i16bit;  // Compressed instr at head
        logic        i32bit;  // Full width instr at head
        logic [31:0] instr;   // Oldest 4 buffer bytes
        logic [1:0]  ferr;    // Error tag per halfword
    } fetch_out_t;

    typedef struct packed {
        logic            valid;   // Held until acknowledged
        logic [xlen-1:0] target;  // Halfword aligned
    } cf_req_t;

endpackage

`default_nettype wire
